// ==== ethbfm_settings.svh ====
// Ethernet BFM settings
// Frame limits, echo timing, node MAC base, halt EtherType and
// the PHY identity words returned over MDIO
`ifndef ETHBFM_SETTINGS_SVH
`define ETHBFM_SETTINGS_SVH

// Largest buffered frame in bytes, longer ones are dropped
`define ETHBFM_MAX_FRAME   64
// Header only: dst MAC, src MAC, EtherType
`define ETHBFM_MIN_FRAME   14
// Idle clk cycles from end of reception to first echoed byte
`define ETHBFM_IFG         12

// MAC of node 0, node n answers to base + n
`define ETHBFM_MAC_BASE    48'h0200_5E10_0000
// EtherType that requests a simulation halt
`define ETHBFM_HALT_TYPE   16'h88B5

// Clause-22 identity and status words
`define ETHBFM_PHY_STATUS  16'h796D
`define ETHBFM_PHY_ID1     16'h0022
// Low nibble gets replaced by the node number
`define ETHBFM_PHY_ID2     16'h1620

`endif

// ==== ethbfm_pkg.sv ====
// Ethernet BFM shared types
// GMII and RGMII beat structs, MDIO opcodes and the byte offsets
// of the header fields within a frame
`default_nettype none

package ethbfm_pkg;

  // ------------------------------------------------------------------
  // Interface beats
  // ------------------------------------------------------------------

  // One GMII beat on clk, 10 bits
  typedef struct packed {
    logic [7:0] data;
    logic       en;
    logic       er;
  } gmii_t;

  // One RGMII half-cycle on clkx2
  typedef struct packed {
    logic [3:0] d;
    logic       ctl;
  } rgmii_t;

  // Clause-22 opcode field
  typedef enum logic [1:0] {
    MDIO_OP_WRITE = 2'b01,
    MDIO_OP_READ  = 2'b10
  } mdio_op_e;

  // ------------------------------------------------------------------
  // Frame layout, no preamble, SFD or FCS
  // ------------------------------------------------------------------

  // Destination MAC starts the frame
  localparam int DST_OFS   = 0;
  // Source MAC follows
  localparam int SRC_OFS   = 6;
  // EtherType, big endian
  localparam int TYPE_OFS  = 12;
  // Bytes per MAC address
  localparam int MAC_BYTES = 6;

endpackage

`default_nettype wire

// ==== gmii_rgmii_conv.sv ====
// GMII to RGMII converter for one port
// TX splits each GMII byte on clk into two nibbles on clkx2,
// low nibble with en first, then high nibble with en^er.
// RX rebuilds a GMII beat from each received nibble pair.
`timescale 1ns/1ps
`default_nettype none

module gmii_rgmii_conv
  import ethbfm_pkg::*;
(
  input  logic   clk,
  input  logic   clkx2,
  input  logic   rst,

  // GMII side towards the responder
  input  gmii_t  gmii_tx,
  output rgmii_t rgmii_tx,

  // RGMII side towards the host
  input  rgmii_t rgmii_rx,
  output gmii_t  gmii_rx
);

  // High during the second half of each clk cycle
  logic   second;
  // Registered TX beat
  gmii_t  tx_q;
  // First half of an RX nibble pair
  rgmii_t rx_lo;

  // ------------------------------------------------------------------
  // Phase tracking
  // ------------------------------------------------------------------

  // Reset parks phase low, rst drops right after a clk edge
  // so the next clkx2 edge is the mid-cycle one
  always_ff @(posedge clkx2)
  begin
    if (rst)
    begin
      second <= 1'b0;
    end
    else
    begin
      second <= ~second;
    end
  end

  // ------------------------------------------------------------------
  // GMII to RGMII
  // ------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      tx_q <= '0;
    end
    else
    begin
      tx_q <= gmii_tx;
    end
  end

  // Nibble select by phase
  always_comb
  begin
    if (second)
    begin
      rgmii_tx = '{d: tx_q.data[7:4], ctl: tx_q.en ^ tx_q.er};
    end
    else
    begin
      rgmii_tx = '{d: tx_q.data[3:0], ctl: tx_q.en};
    end
  end

  // ------------------------------------------------------------------
  // RGMII to GMII
  // ------------------------------------------------------------------

  // Mid-cycle edge holds the low nibble
  always_ff @(posedge clkx2)
  begin
    if (!second)
    begin
      rx_lo <= rgmii_rx;
    end
  end

  // High nibble still on the pins at the clk edge
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      gmii_rx <= '0;
    end
    else
    begin
      gmii_rx.data <= {rgmii_rx.d, rx_lo.d};
      gmii_rx.en   <= rx_lo.ctl;
      gmii_rx.er   <= rx_lo.ctl ^ rgmii_rx.ctl;
    end
  end

endmodule

`default_nettype wire

// ==== frame_echo.sv ====
// Ethernet frame responder for one node
// Buffers a received GMII frame, filters on errors, length and
// destination, then echoes it with swapped MACs after the IFG.
// A halt EtherType frame raises a sticky halt instead.
`timescale 1ns/1ps
`default_nettype none
`include "ethbfm_settings.svh"

module frame_echo
  import ethbfm_pkg::*;
#(
  parameter int NODE = 0
)
(
  input  logic  clk,
  input  logic  rst,
  input  gmii_t rx,
  output gmii_t tx,
  output logic  halt
);

  localparam int          MAX_LEN  = `ETHBFM_MAX_FRAME;
  localparam int          IDX_W    = $clog2(MAX_LEN);
  // Counts to MAX_LEN+1 to flag oversize frames
  localparam int          LEN_W    = $clog2(MAX_LEN + 2);
  localparam int          IFG_W    = $clog2(`ETHBFM_IFG + 1);
  localparam logic [47:0] NODE_MAC = 48'(`ETHBFM_MAC_BASE + NODE);

  typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_SEND} state_e;

  logic [7:0]       frame_mem [MAX_LEN];
  state_e           state;
  logic             prev_en;
  logic             cap;
  logic             bad;
  logic [LEN_W-1:0] rx_len;
  logic [LEN_W-1:0] tx_idx;
  logic [LEN_W-1:0] rd_idx;
  logic [IDX_W-1:0] rd_pos;
  logic [IFG_W-1:0] ifg_cnt;
  logic [47:0]      dst_mac;
  logic [47:0]      mac_sh;
  logic [15:0]      eth_type;
  logic [7:0]       echo_data;
  logic [7:0]       tx_data;
  logic             tx_en;
  logic             start_cap;
  logic             frame_end;
  logic             frame_ok;

  // New frames only taken while idle
  assign start_cap = rx.en && !prev_en && (state == ST_IDLE);
  assign frame_end = cap && !rx.en;

  // ------------------------------------------------------------------
  // Receive and buffer
  // ------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      prev_en <= 1'b0;
      cap     <= 1'b0;
      bad     <= 1'b0;
      rx_len  <= '0;
    end
    else
    begin
      prev_en <= rx.en;
      if (start_cap)
      begin
        cap    <= 1'b1;
        bad    <= rx.er;
        rx_len <= LEN_W'(1);
      end
      else if (cap && rx.en)
      begin
        bad <= bad | rx.er;
        // Saturate one past the limit
        if (rx_len <= LEN_W'(MAX_LEN))
        begin
          rx_len <= rx_len + 1'b1;
        end
      end
      else if (frame_end)
      begin
        cap <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (start_cap)
    begin
      frame_mem[0] <= rx.data;
    end
    else if (cap && rx.en && (rx_len < LEN_W'(MAX_LEN)))
    begin
      frame_mem[rx_len[IDX_W-1:0]] <= rx.data;
    end
  end

  // ------------------------------------------------------------------
  // Filter
  // ------------------------------------------------------------------

  always_comb
  begin
    for (int i = 0; i < MAC_BYTES; i++)
    begin
      dst_mac[47-8*i -: 8] = frame_mem[DST_OFS+i];
    end
  end

  assign eth_type = {frame_mem[TYPE_OFS], frame_mem[TYPE_OFS+1]};

  // Own MAC or broadcast, clean and within length limits
  assign frame_ok = !bad &&
                    (rx_len >= LEN_W'(`ETHBFM_MIN_FRAME)) &&
                    (rx_len <= LEN_W'(MAX_LEN)) &&
                    ((dst_mac == NODE_MAC) || (dst_mac == '1));

  // ------------------------------------------------------------------
  // Echo byte select
  // ------------------------------------------------------------------

  assign rd_idx = (state == ST_SEND) ? tx_idx : '0;
  assign rd_pos = rd_idx[IDX_W-1:0];
  assign mac_sh = NODE_MAC << (8 * (rd_idx - LEN_W'(SRC_OFS)));

  always_comb
  begin
    if (rd_idx < LEN_W'(SRC_OFS))
    begin
      // New destination is the old source
      echo_data = frame_mem[rd_pos + IDX_W'(SRC_OFS)];
    end
    else if (rd_idx < LEN_W'(TYPE_OFS))
    begin
      echo_data = mac_sh[47:40];
    end
    else
    begin
      echo_data = frame_mem[rd_pos];
    end
  end

  // ------------------------------------------------------------------
  // Echo FSM
  // ------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state   <= ST_IDLE;
      ifg_cnt <= '0;
      tx_idx  <= '0;
      tx_en   <= 1'b0;
      halt    <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (frame_end && frame_ok)
          begin
            if (eth_type == `ETHBFM_HALT_TYPE)
            begin
              halt <= 1'b1;
            end
            else
            begin
              state   <= ST_WAIT;
              // Detect and launch edges use up two of the IFG cycles
              ifg_cnt <= IFG_W'(`ETHBFM_IFG - 2);
            end
          end
        end
        ST_WAIT:
        begin
          // First byte lands IFG cycles after en fell
          if (ifg_cnt == '0)
          begin
            state  <= ST_SEND;
            tx_en  <= 1'b1;
            tx_idx <= LEN_W'(1);
          end
          else
          begin
            ifg_cnt <= ifg_cnt - 1'b1;
          end
        end
        ST_SEND:
        begin
          if (tx_idx == rx_len)
          begin
            tx_en <= 1'b0;
            state <= ST_IDLE;
          end
          else
          begin
            tx_idx <= tx_idx + 1'b1;
          end
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    tx_data <= echo_data;
  end

  assign tx = '{data: tx_data, en: tx_en, er: 1'b0};

endmodule

`default_nettype wire

// ==== phy_mdio_regs.sv ====
// Clause-22 MDIO PHY slave
// Bit-serial frame decoder with a small register file. Answers
// only at PHY address NODE mod 32 and drives mdio_out from the
// second turnaround bit of a read.
`timescale 1ns/1ps
`default_nettype none
`include "ethbfm_settings.svh"

module phy_mdio_regs
  import ethbfm_pkg::*;
#(
  parameter int NODE = 0
)
(
  input  logic mdioclk,
  input  logic rst,
  input  logic mdio_in,
  output logic mdio_out,
  output logic mdio_en
);

  localparam logic [4:0]  PHY_ADDR = 5'(NODE % 32);
  localparam logic [15:0] ID2_BASE = `ETHBFM_PHY_ID2;
  localparam logic [15:0] PHY_ID2  = {ID2_BASE[15:4], 4'(NODE)};

  typedef enum logic [2:0] {ST_PRE, ST_START, ST_HDR, ST_TA, ST_DATA} state_e;

  state_e      state;
  logic [5:0]  pre_cnt;
  logic [3:0]  bit_cnt;
  // Opcode, PHY address, register address
  logic [11:0] hdr;
  logic [15:0] data_sh;
  logic [15:0] regs [16];
  logic [15:0] rd_word;
  mdio_op_e    op;
  logic [4:0]  reg_ad;
  logic        addr_hit;
  logic        wr_ok;

  assign op       = mdio_op_e'(hdr[11:10]);
  assign addr_hit = (hdr[9:5] == PHY_ADDR);
  assign reg_ad   = hdr[4:0];

  // Reg 0 and scratch 4..15 writable
  assign wr_ok = (op == MDIO_OP_WRITE) && addr_hit && !reg_ad[4] &&
                 !(reg_ad[3:0] inside {4'd1, 4'd2, 4'd3});

  // ------------------------------------------------------------------
  // Read mux
  // ------------------------------------------------------------------

  always_comb
  begin
    if (reg_ad[4])
    begin
      rd_word = '0;
    end
    else
    begin
      case (reg_ad[3:0])
        4'd1:    rd_word = `ETHBFM_PHY_STATUS;
        4'd2:    rd_word = `ETHBFM_PHY_ID1;
        4'd3:    rd_word = PHY_ID2;
        default: rd_word = regs[reg_ad[3:0]];
      endcase
    end
  end

  // ------------------------------------------------------------------
  // Frame FSM
  // ------------------------------------------------------------------

  always_ff @(posedge mdioclk)
  begin
    if (rst)
    begin
      state    <= ST_PRE;
      pre_cnt  <= '0;
      bit_cnt  <= '0;
      mdio_en  <= 1'b0;
      mdio_out <= 1'b0;
    end
    else
    begin
      case (state)
        ST_PRE:
        begin
          // 32 ones then the 0 of the start pattern
          if (mdio_in)
          begin
            if (pre_cnt != 6'd32)
            begin
              pre_cnt <= pre_cnt + 1'b1;
            end
          end
          else if (pre_cnt == 6'd32)
          begin
            state <= ST_START;
          end
          else
          begin
            pre_cnt <= '0;
          end
        end
        ST_START:
        begin
          pre_cnt <= '0;
          bit_cnt <= '0;
          state   <= mdio_in ? ST_HDR : ST_PRE;
        end
        ST_HDR:
        begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 4'd11)
          begin
            bit_cnt <= '0;
            state   <= ST_TA;
          end
        end
        ST_TA:
        begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == '0)
          begin
            // Slave takes the line for TA bit 2, driving zero
            mdio_en  <= (op == MDIO_OP_READ) && addr_hit;
            mdio_out <= 1'b0;
          end
          else
          begin
            bit_cnt  <= '0;
            state    <= ST_DATA;
            mdio_out <= mdio_en & data_sh[15];
          end
        end
        ST_DATA:
        begin
          bit_cnt  <= bit_cnt + 1'b1;
          mdio_out <= mdio_en & data_sh[15];
          if (bit_cnt == 4'd15)
          begin
            state    <= ST_PRE;
            mdio_en  <= 1'b0;
            mdio_out <= 1'b0;
          end
        end
        default:
        begin
          state <= ST_PRE;
        end
      endcase
    end
  end

  // ------------------------------------------------------------------
  // Shift registers and register file
  // ------------------------------------------------------------------

  // Read data shifts out MSB first, write data shifts in
  always_ff @(posedge mdioclk)
  begin
    if (state == ST_HDR)
    begin
      hdr <= {hdr[10:0], mdio_in};
    end
    if ((state == ST_TA) && (bit_cnt == '0))
    begin
      data_sh <= rd_word;
    end
    else if ((state == ST_TA) || (state == ST_DATA))
    begin
      data_sh <= {data_sh[14:0], mdio_in};
    end
  end

  always_ff @(posedge mdioclk)
  begin
    if (rst)
    begin
      for (int i = 0; i < 16; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if ((state == ST_DATA) && (bit_cnt == 4'd15) && wr_ok)
    begin
      regs[reg_ad[3:0]] <= {data_sh[14:0], mdio_in};
    end
  end

endmodule

`default_nettype wire

// ==== bfm_ethernet.sv ====
// Multi-port Ethernet BFM top level
// Per port a frame responder, an optional GMII to RGMII converter
// and a clause-22 MDIO PHY slave. Halt requests of all ports are ORed.
`timescale 1ns/1ps
`default_nettype none

module bfm_ethernet
  import ethbfm_pkg::*;
#(
  parameter int START_NODE = 1,
  parameter int NUM_PORTS  = 4,
  parameter bit RGMII      = 1
)
(
  input  logic                 clk,
  input  logic                 clkx2,
  input  logic                 mdioclk,
  input  logic                 rst,

  // Host to BFM and BFM to host streams
  input  gmii_t                phy_rx [0:NUM_PORTS-1],
  output gmii_t                phy_tx [0:NUM_PORTS-1],

  // Split MDIO line per port
  input  logic [NUM_PORTS-1:0] mdio_in,
  output logic [NUM_PORTS-1:0] mdio_out,
  output logic [NUM_PORTS-1:0] mdio_en,

  output logic                 halt_req
);

  logic [NUM_PORTS-1:0] halt;

  assign halt_req = |halt;

  // ------------------------------------------------------------------
  // Per-port blocks
  // ------------------------------------------------------------------

  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : g_port
    gmii_t echo_rx;
    gmii_t echo_tx;

    if (RGMII)
    begin : g_rgmii
      rgmii_t rg_tx;
      rgmii_t rg_rx;

      // RGMII rides on data[3:0] and en
      assign rg_rx = '{d: phy_rx[p].data[3:0], ctl: phy_rx[p].en};

      gmii_rgmii_conv i_conv (
        .clk      (clk),
        .clkx2    (clkx2),
        .rst      (rst),
        .gmii_tx  (echo_tx),
        .rgmii_tx (rg_tx),
        .rgmii_rx (rg_rx),
        .gmii_rx  (echo_rx)
      );

      // Upper nibble and er unused in RGMII mode
      assign phy_tx[p] = '{data: {4'h0, rg_tx.d}, en: rg_tx.ctl, er: 1'b0};
    end
    else
    begin : g_gmii
      assign echo_rx   = phy_rx[p];
      assign phy_tx[p] = echo_tx;
    end

    frame_echo #(
      .NODE (START_NODE + p)
    ) i_frame_echo (
      .clk  (clk),
      .rst  (rst),
      .rx   (echo_rx),
      .tx   (echo_tx),
      .halt (halt[p])
    );

    phy_mdio_regs #(
      .NODE (START_NODE + p)
    ) i_phy_mdio (
      .mdioclk  (mdioclk),
      .rst      (rst),
      .mdio_in  (mdio_in[p]),
      .mdio_out (mdio_out[p]),
      .mdio_en  (mdio_en[p])
    );
  end

endmodule

`default_nettype wire

// ==== tb_clkgen.sv ====
// Testbench clock and reset source
// clk at 40 ns, clkx2 at 20 ns rising with clk, mdioclk at 80 ns.
// Reset held for three clk cycles and released just after an edge
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen
(
  output logic clk,
  output logic clkx2,
  output logic mdioclk,
  output logic rst
);

  // First rising clk edge at 20 ns
  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Starts high so its rising edges line up with clk
  initial
  begin
    clkx2 = 1'b1;
    forever #10 clkx2 = ~clkx2;
  end

  initial
  begin
    mdioclk = 1'b0;
    forever #40 mdioclk = ~mdioclk;
  end

  // Release 2 ns after an edge, the RGMII phase depends on it
  initial
  begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #2 rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb_bfm_ethernet.sv ====
// Testbench for the Ethernet BFM, two ports, RGMII mode
// Reads frames, expected echoes and MDIO transactions from the stim
// file, drives RGMII and MDIO and checks echoes, drops and halt
`timescale 1ns/1ps
`default_nettype none
`include "ethbfm_settings.svh"

module tb_bfm_ethernet
  import ethbfm_pkg::*;
;

  logic        clk;
  logic        clkx2;
  logic        mdioclk;
  logic        gen_rst;
  logic        rerst;
  logic        rst;
  gmii_t       phy_rx [0:1];
  gmii_t       phy_tx [0:1];
  logic [1:0]  mdio_in;
  logic [1:0]  mdio_out;
  logic [1:0]  mdio_en;
  logic        halt_req;

  integer      seed = 32'h3ffbbcf6;
  int          errors;
  int          err_mark;
  int          pass_cnt;
  int          fail_cnt;
  string       cur_test;
  // Captured and expected echo bytes per port
  logic [7:0]  got0 [$];
  logic [7:0]  got1 [$];
  logic [7:0]  exp0 [$];
  logic [7:0]  exp1 [$];
  logic [7:0]  frame_q [$];
  // MDIO line state seen mid-bit
  logic        en_any;
  logic        last_out;

  assign rst = gen_rst | rerst;

  tb_clkgen i_clkgen (
    .clk     (clk),
    .clkx2   (clkx2),
    .mdioclk (mdioclk),
    .rst     (gen_rst)
  );

  bfm_ethernet #(
    .START_NODE (3),
    .NUM_PORTS  (2),
    .RGMII      (1)
  ) i_bfm_ethernet (
    .clk      (clk),
    .clkx2    (clkx2),
    .mdioclk  (mdioclk),
    .rst      (rst),
    .phy_rx   (phy_rx),
    .phy_tx   (phy_tx),
    .mdio_in  (mdio_in),
    .mdio_out (mdio_out),
    .mdio_en  (mdio_en),
    .halt_req (halt_req)
  );

  // ------------------------------------------------------------------
  // Bookkeeping
  // ------------------------------------------------------------------

  task automatic report_mismatch(input string what, input logic [47:0] expv,
                                 input logic [47:0] actv);
    $display("CHECK FAILED %s: %s expected %0h actual %0h", cur_test, what, expv, actv);
    errors++;
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    err_mark = errors;
  endtask

  task automatic finish_test();
    if (errors == err_mark)
    begin
      $display("PASS %s", cur_test);
      pass_cnt++;
    end
    else
    begin
      $display("FAIL %s", cur_test);
      fail_cnt++;
    end
  endtask

  // ------------------------------------------------------------------
  // RGMII host model
  // ------------------------------------------------------------------

  // Low nibble with en before the mid edge, high nibble with en^er after
  task automatic send_frames(input int mask, input int er_beat);
    for (int i = 0; i < frame_q.size(); i++)
    begin
      @(posedge clk);
      #2;
      for (int p = 0; p < 2; p++)
      begin
        if (mask[p])
        begin
          phy_rx[p] = '{data: {4'h0, frame_q[i][3:0]}, en: 1'b1, er: 1'b0};
        end
      end
      #20;
      for (int p = 0; p < 2; p++)
      begin
        if (mask[p])
        begin
          phy_rx[p] = '{data: {4'h0, frame_q[i][7:4]}, en: (i != er_beat), er: 1'b0};
        end
      end
    end
    @(posedge clk);
    #2;
    phy_rx[0] = '0;
    phy_rx[1] = '0;
  endtask

  // Collects one echo, gives up after limit idle cycles
  task automatic capture_echo(input int port, input int limit);
    gmii_t      lo;
    gmii_t      hi;
    int         waited;
    int         beats;
    bit         started;
    bit         done_f;
    logic [7:0] b;
    waited  = 0;
    beats   = 0;
    started = 1'b0;
    done_f  = 1'b0;
    while (!done_f)
    begin
      @(posedge clk);
      #10;
      lo = phy_tx[port];
      #20;
      hi = phy_tx[port];
      // Upper nibble and er stay zero in RGMII mode
      assert ({lo.data[7:4], lo.er, hi.data[7:4], hi.er} == 10'd0)
      else report_mismatch("phy_tx unused bits", 48'd0,
                           48'({lo.data[7:4], lo.er, hi.data[7:4], hi.er}));
      if (lo.en)
      begin
        started = 1'b1;
        beats++;
        b = {hi.data[3:0], lo.data[3:0]};
        if (port == 0)
          got0.push_back(b);
        else
          got1.push_back(b);
        assert (lo.en == hi.en)
        else report_mismatch("echo er", 48'd0, 48'd1);
        // Runaway stream guard
        if (beats > `ETHBFM_MAX_FRAME + 4)
          done_f = 1'b1;
      end
      else if (started)
      begin
        done_f = 1'b1;
      end
      else
      begin
        waited++;
        if (waited >= limit)
          done_f = 1'b1;
      end
    end
  endtask

  task automatic check_echo(input int port);
    logic [7:0] e [$];
    logic [7:0] g [$];
    if (port == 0)
    begin
      e = exp0;
      g = got0;
    end
    else
    begin
      e = exp1;
      g = got1;
    end
    if ((e.size() > 0) && (g.size() == 0))
    begin
      $display("Timeout in %s: no echo appeared on port %0d", cur_test, port);
      errors++;
    end
    else
    begin
      assert (g.size() == e.size())
      else report_mismatch($sformatf("port %0d echo length", port), 48'(e.size()),
                           48'(g.size()));
      if (g.size() == e.size())
      begin
        for (int i = 0; i < e.size(); i++)
        begin
          assert (g[i] == e[i])
          else report_mismatch($sformatf("port %0d byte %0d", port, i), 48'(e[i]),
                               48'(g[i]));
        end
      end
    end
  endtask

  // ------------------------------------------------------------------
  // MDIO master model
  // ------------------------------------------------------------------

  // Drive one bit, then look at the slave mid-bit
  task automatic mdio_bit(input int port, input logic b);
    @(posedge mdioclk);
    #2;
    mdio_in[port] = b;
    #30;
    if (mdio_en[port])
      en_any = 1'b1;
    last_out = mdio_out[port];
  endtask

  task automatic mdio_xfer(input int port, input bit is_rd, input logic [4:0] phy,
                           input logic [4:0] ra, input logic [15:0] wdata,
                           output logic [15:0] rdata);
    logic [13:0] hdr;
    hdr    = {2'b01, (is_rd ? 2'b10 : 2'b01), phy, ra};
    en_any = 1'b0;
    rdata  = '0;
    for (int i = 0; i < 32; i++)
      mdio_bit(port, 1'b1);
    for (int i = 13; i >= 0; i--)
      mdio_bit(port, hdr[i]);
    // Turnaround, master lets go on a read
    mdio_bit(port, 1'b1);
    mdio_bit(port, is_rd ? 1'b1 : 1'b0);
    for (int i = 15; i >= 0; i--)
    begin
      mdio_bit(port, is_rd ? 1'b1 : wdata[i]);
      rdata[i] = last_out;
    end
    // Idle bit so the slave sees its last edge
    mdio_bit(port, 1'b1);
  endtask

  // ------------------------------------------------------------------
  // Reset and status
  // ------------------------------------------------------------------

  task automatic check_idle_outputs();
    #10;
    assert (halt_req == 1'b0)
    else report_mismatch("halt_req", 48'd0, 48'(halt_req));
    assert ((phy_tx[0].en | phy_tx[1].en) == 1'b0)
    else report_mismatch("phy_tx en", 48'd0, 48'({phy_tx[1].en, phy_tx[0].en}));
    assert (mdio_en == 2'b00)
    else report_mismatch("mdio_en", 48'd0, 48'(mdio_en));
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #2;
    rerst = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    rerst = 1'b0;
    @(posedge clk);
  endtask

  // ------------------------------------------------------------------
  // Stim file
  // ------------------------------------------------------------------

  task automatic read_frame(input int fd, output int mask, output int er_beat,
                            output int len);
    int          code;
    int          nbytes;
    logic [31:0] v;
    string       name;
    code = $fscanf(fd, " %s %d %d %d %d", name, mask, er_beat, len, nbytes);
    start_test(name);
    frame_q.delete();
    for (int i = 0; i < len; i++)
    begin
      if (i < nbytes)
        code = $fscanf(fd, " %h", v);
      else
        v = 32'($random(seed));
      frame_q.push_back(v[7:0]);
    end
  endtask

  task automatic run_frame_test(input int fd);
    int          mask;
    int          er_beat;
    int          len;
    int          elen;
    int          code;
    logic [31:0] v;
    string       tag;
    logic [7:0]  eq [$];
    read_frame(fd, mask, er_beat, len);
    for (int p = 0; p < 2; p++)
    begin
      if (mask[p])
      begin
        code = $fscanf(fd, " %s %d", tag, elen);
        eq.delete();
        for (int i = 0; i < elen; i++)
        begin
          code = $fscanf(fd, " %h", v);
          eq.push_back(v[7:0]);
        end
        if (p == 0)
          exp0 = eq;
        else
          exp1 = eq;
      end
    end
    got0.delete();
    got1.delete();
    send_frames(mask, er_beat);
    fork
      begin
        if (mask[0])
          capture_echo(0, 2 * len + `ETHBFM_IFG);
      end
      begin
        if (mask[1])
          capture_echo(1, 2 * len + `ETHBFM_IFG);
      end
    join
    for (int p = 0; p < 2; p++)
    begin
      if (mask[p])
        check_echo(p);
    end
    finish_test();
  endtask

  task automatic run_halt_test(input int fd);
    int mask;
    int er_beat;
    int len;
    int n;
    read_frame(fd, mask, er_beat, len);
    exp0.delete();
    got0.delete();
    send_frames(mask, er_beat);
    n = 0;
    while (!halt_req && (n < `ETHBFM_IFG + 8))
    begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!halt_req)
    begin
      $display("Timeout in %s: halt_req never rose", cur_test);
      errors++;
    end
    // Halt frame must not come back
    capture_echo(0, 2 * len + `ETHBFM_IFG);
    check_echo(0);
    assert (halt_req == 1'b1)
    else report_mismatch("halt_req held", 48'd1, 48'(halt_req));
    finish_test();
  endtask

  task automatic run_mdio_test(input int fd);
    int          code;
    int          port;
    int          phy;
    int          ra;
    int          answer;
    logic [31:0] wdata;
    logic [31:0] expv;
    logic [15:0] rdata;
    string       name;
    string       op_s;
    code = $fscanf(fd, " %s %d %s %d %d %h %h %d", name, port, op_s, phy, ra,
                   wdata, expv, answer);
    start_test(name);
    mdio_xfer(port, op_s == "R", 5'(phy), 5'(ra), wdata[15:0], rdata);
    if (answer != 0)
    begin
      assert (en_any == 1'b1)
      else report_mismatch("mdio_en", 48'd1, 48'd0);
      assert (rdata == expv[15:0])
      else report_mismatch("read data", 48'(expv[15:0]), 48'(rdata));
    end
    else
    begin
      assert (en_any == 1'b0)
      else report_mismatch("mdio_en", 48'd0, 48'd1);
    end
    finish_test();
  endtask

  task automatic run_stim(input int fd);
    int    code;
    string kind;
    string line;
    string name;
    code = $fscanf(fd, " %s", kind);
    while (code == 1)
    begin
      if (kind == "#")
      begin
        code = $fgets(line, fd);
      end
      else if (kind == "F")
      begin
        run_frame_test(fd);
      end
      else if (kind == "H")
      begin
        run_halt_test(fd);
      end
      else if (kind == "M")
      begin
        run_mdio_test(fd);
      end
      else if (kind == "R")
      begin
        code = $fscanf(fd, " %s", name);
        start_test(name);
        apply_reset();
        check_idle_outputs();
        finish_test();
      end
      else
      begin
        $display("Unknown record %s in the stim file", kind);
        errors++;
      end
      code = $fscanf(fd, " %s", kind);
    end
  endtask

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------

  initial
  begin
    int fd;
    int n;
    phy_rx[0] = '0;
    phy_rx[1] = '0;
    mdio_in   = 2'b11;
    rerst     = 1'b0;
    errors    = 0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    en_any    = 1'b0;
    last_out  = 1'b0;
    n = 0;
    // Reset is surely up by the first edge
    @(posedge clk);
    while (rst && (n < 20))
    begin
      @(posedge clk);
      n++;
    end
    start_test("reset_state");
    if (rst)
    begin
      $display("Timeout: reset never released");
      errors++;
    end
    check_idle_outputs();
    finish_test();
    fd = $fopen("bfm_ethernet_stim.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the stim file bfm_ethernet_stim.txt");
      errors++;
    end
    else
    begin
      run_stim(fd);
      $fclose(fd);
    end
    $display("Tests passed %0d, tests failed %0d, failed checks %0d",
             pass_cnt, fail_cnt, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bfm_ethernet_stim.txt ====
# F|H name port_mask er_beat(-1 none) len given_bytes bytes.., rest random; E len bytes per port
# M name port R|W phy reg wdata(hex) expected(hex) answer ; R name applies reset
F unicast_p0 1 -1 16 16 02 00 5E 10 00 03 02 AA BB CC DD 01 08 00 12 34
E 16 02 AA BB CC DD 01 02 00 5E 10 00 03 08 00 12 34
F broadcast_p0 1 -1 16 16 FF FF FF FF FF FF 02 AA BB CC DD 02 88 B6 5A A5
E 16 02 AA BB CC DD 02 02 00 5E 10 00 03 88 B6 5A A5
F foreign_dst 1 -1 16 16 02 00 5E 10 00 09 02 AA BB CC DD 01 08 00 12 34
E 0
F rx_error 1 3 16 16 02 00 5E 10 00 03 02 AA BB CC DD 01 08 00 12 34
E 0
F oversize_p1 2 -1 70 14 02 00 5E 10 00 04 02 AA BB CC DD 01 08 00
E 0
F dual_port 3 -1 16 16 FF FF FF FF FF FF 02 AA BB CC DD 03 08 06 00 01
E 16 02 AA BB CC DD 03 02 00 5E 10 00 03 08 06 00 01
E 16 02 AA BB CC DD 03 02 00 5E 10 00 04 08 06 00 01
M status_p0 0 R 3 1 0000 796D 1
M id1_p0 0 R 3 2 0000 0022 1
M id2_p0 0 R 3 3 0000 1623 1
M status_p1 1 R 4 1 0000 796D 1
M id1_p1 1 R 4 2 0000 0022 1
M id2_p1 1 R 4 3 0000 1624 1
M wr_scratch_p0 0 W 3 5 BEEF 0000 0
M rd_scratch_p0 0 R 3 5 0000 BEEF 1
M wr_scratch_p1 1 W 4 5 1234 0000 0
M rd_scratch_p1 1 R 4 5 0000 1234 1
M rd_unused_p0 0 R 3 20 0000 0000 1
M absent_phy 0 R 7 1 0000 0000 0
H halt_p0 1 -1 16 16 02 00 5E 10 00 03 02 AA BB CC DD 04 88 B5 00 00
R reset_clears_halt

// ==== bfm_ethernet.f ====
+incdir+.
ethbfm_pkg.sv
gmii_rgmii_conv.sv
frame_echo.sv
phy_mdio_regs.sv
bfm_ethernet.sv
tb_clkgen.sv
tb_bfm_ethernet.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the Ethernet BFM testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_bfm_ethernet -f bfm_ethernet.f

./obj_dir/Vtb_bfm_ethernet > sim.log 2>&1
cat sim.log

if grep -qx "No errors" sim.log; then
  exit 0
else
  exit 1
fi
